// File: common/sys86_macros.svh
`ifndef SYS86_MACROS_SVH
`define SYS86_MACROS_SVH

//////////////////////////////////////////////////
// Bus widths and frame
//////////////////////////////////////////////////

`define SYS86_ADDR_W        16
`define SYS86_DATA_W        8
`define SYS86_BUS_ADDR_W    13
`define SYS86_ROM_ADDR_W    15

// Four clk_6m cycles per bus frame, two per CPU slot
`define SYS86_FRAME_CYCLES  4
`define SYS86_RESET_CYCLES  16

//////////////////////////////////////////////////
// Address map
//////////////////////////////////////////////////

`define SYS86_WIN_1K        16'h0400
`define SYS86_WIN_8K        16'h2000

// Video regions, same on both CPUs
`define SYS86_SCROLL0_BASE  16'h0000
`define SYS86_SCROLL1_BASE  16'h2000
`define SYS86_OBJECT_BASE   16'h4000

// Master map
`define SYS86_M_ROM_LO_BASE 16'h6000
`define SYS86_M_ROM_HI_BASE 16'hA000
`define SYS86_M_ROM_HI_SIZE 16'h6000
`define SYS86_M_LATCH0      16'h8000
`define SYS86_M_LATCH1      16'h8400
`define SYS86_M_BACKCOLOR   16'h8800
`define SYS86_M_BANK        16'h9000
`define SYS86_M_IRQ_ACK     16'h9400
`define SYS86_M_RESET       16'h9800

// Sub map, ROM_HI overlaps the write registers
`define SYS86_S_ROM_LO_BASE 16'h6000
`define SYS86_S_ROM_HI_BASE 16'h8000
`define SYS86_S_ROM_HI_SIZE 16'h8000
`define SYS86_S_LATCH0      16'h8000
`define SYS86_S_LATCH1      16'h8400
`define SYS86_S_IRQ_ACK     16'h8800

`endif

// File: common/sys86_bus_pkg.sv
`include "sys86_macros.svh"

package sys86_bus_pkg;

	// Decoded target of one CPU access
	typedef enum logic [3:0] {
		REG_NONE,
		REG_SCROLL0,
		REG_SCROLL1,
		REG_OBJECT,
		REG_LATCH0,
		REG_LATCH1,
		REG_BACKCOLOR,
		REG_ROM_LO,
		REG_ROM_HI,
		REG_BANK,
		REG_IRQ_ACK,
		REG_RESET
	} region_e;

	// Offset compare, so a window may end at the top of the map
	function automatic logic in_window(
		input logic [`SYS86_ADDR_W-1:0] addr,
		input logic [`SYS86_ADDR_W-1:0] base,
		input logic [`SYS86_ADDR_W-1:0] size
	);
		logic [`SYS86_ADDR_W-1:0] offset;
		offset = addr - base;
		return offset < size;
	endfunction

	// Regions that live on the shared video bus
	function automatic logic is_video(input region_e region);
		return region == REG_SCROLL0 || region == REG_SCROLL1 || region == REG_OBJECT;
	endfunction

endpackage

// File: common/sys86_cpu_pkg.sv
package sys86_cpu_pkg;

	// Bus frame, master slot then sub slot
	typedef enum logic [1:0] {
		PH_MASTER_A,
		PH_MASTER_B,
		PH_SUB_A,
		PH_SUB_B
	} phase_e;

	function automatic logic is_master_slot(input phase_e phase);
		return phase == PH_MASTER_A || phase == PH_MASTER_B;
	endfunction

	// B cycle carries the E strobe and the write strobes
	function automatic logic is_b_cycle(input phase_e phase);
		return phase == PH_MASTER_B || phase == PH_SUB_B;
	endfunction

endpackage

// File: verilog/cpu_timing.sv
`timescale 1ns/10ps

`include "sys86_macros.svh"

module cpu_timing (
	input  logic                  clk_6m,
	input  logic                  rst_n,
	input  logic                  reset_req,
	output sys86_cpu_pkg::phase_e phase,
	output logic                  master_e,
	output logic                  sub_e,
	output logic                  cpu_reset_n
);

	localparam int CNT_W = $clog2(`SYS86_RESET_CYCLES + 1);

	logic [CNT_W-1:0] reset_cnt;

	//////////////////////////////////////////////////
	// Slot counter
	//////////////////////////////////////////////////

	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n) begin
			phase <= sys86_cpu_pkg::PH_MASTER_A;
		end else begin
			phase <= sys86_cpu_pkg::phase_e'(phase + 2'd1);
		end
	end

	assign master_e = (phase == sys86_cpu_pkg::PH_MASTER_B);
	assign sub_e    = (phase == sys86_cpu_pkg::PH_SUB_B);

	//////////////////////////////////////////////////
	// CPU reset stretch
	//////////////////////////////////////////////////

	// Reloads on board reset and on a master reset request
	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n) begin
			reset_cnt <= CNT_W'(`SYS86_RESET_CYCLES);
		end else if (reset_req) begin
			reset_cnt <= CNT_W'(`SYS86_RESET_CYCLES);
		end else if (reset_cnt != '0) begin
			reset_cnt <= reset_cnt - 1'b1;
		end
	end

	assign cpu_reset_n = (reset_cnt == '0);

endmodule

// File: master_decode/master_decode.sv
`timescale 1ns/10ps

`include "sys86_macros.svh"

module master_decode (
	input  logic                     clk_6m,
	input  logic                     rst_n,
	input  logic [`SYS86_ADDR_W-1:0] addr,
	input  logic                     wr,
	input  logic [`SYS86_DATA_W-1:0] wdata,
	input  logic                     master_e,
	input  logic                     vblank,
	output sys86_bus_pkg::region_e   region,
	output logic                     bank,
	output logic                     irq_n,
	output logic                     reset_req
);

	logic vblank_q;
	logic vblank_rise;
	logic irq_pend;

	//////////////////////////////////////////////////
	// Master address map
	//////////////////////////////////////////////////

	always_comb begin
		region = sys86_bus_pkg::REG_NONE;
		if (sys86_bus_pkg::in_window(addr, `SYS86_SCROLL0_BASE, `SYS86_WIN_8K))
			region = sys86_bus_pkg::REG_SCROLL0;
		else if (sys86_bus_pkg::in_window(addr, `SYS86_SCROLL1_BASE, `SYS86_WIN_8K))
			region = sys86_bus_pkg::REG_SCROLL1;
		else if (sys86_bus_pkg::in_window(addr, `SYS86_OBJECT_BASE, `SYS86_WIN_8K))
			region = sys86_bus_pkg::REG_OBJECT;
		else if (!wr) begin
			// Program ROMs answer reads only
			if (sys86_bus_pkg::in_window(addr, `SYS86_M_ROM_LO_BASE, `SYS86_WIN_8K))
				region = sys86_bus_pkg::REG_ROM_LO;
			else if (sys86_bus_pkg::in_window(addr, `SYS86_M_ROM_HI_BASE, `SYS86_M_ROM_HI_SIZE))
				region = sys86_bus_pkg::REG_ROM_HI;
		end else begin
			// Write-only registers
			if (sys86_bus_pkg::in_window(addr, `SYS86_M_LATCH0, `SYS86_WIN_1K))
				region = sys86_bus_pkg::REG_LATCH0;
			else if (sys86_bus_pkg::in_window(addr, `SYS86_M_LATCH1, `SYS86_WIN_1K))
				region = sys86_bus_pkg::REG_LATCH1;
			else if (sys86_bus_pkg::in_window(addr, `SYS86_M_BACKCOLOR, `SYS86_WIN_1K))
				region = sys86_bus_pkg::REG_BACKCOLOR;
			else if (sys86_bus_pkg::in_window(addr, `SYS86_M_BANK, `SYS86_WIN_1K))
				region = sys86_bus_pkg::REG_BANK;
			else if (sys86_bus_pkg::in_window(addr, `SYS86_M_IRQ_ACK, `SYS86_WIN_1K))
				region = sys86_bus_pkg::REG_IRQ_ACK;
			else if (sys86_bus_pkg::in_window(addr, `SYS86_M_RESET, `SYS86_WIN_1K))
				region = sys86_bus_pkg::REG_RESET;
		end
	end

	//////////////////////////////////////////////////
	// Registers, updated at the end of master E
	//////////////////////////////////////////////////

	assign vblank_rise = vblank & ~vblank_q;

	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n) begin
			vblank_q  <= 1'b0;
			irq_pend  <= 1'b0;
			bank      <= 1'b0;
			reset_req <= 1'b0;
		end else begin
			vblank_q  <= vblank;
			reset_req <= master_e && region == sys86_bus_pkg::REG_RESET;
			if (master_e && region == sys86_bus_pkg::REG_BANK) begin
				bank <= wdata[0];
			end
			// New frame wins over an ack in the same cycle
			if (vblank_rise) begin
				irq_pend <= 1'b1;
			end else if (master_e && region == sys86_bus_pkg::REG_IRQ_ACK) begin
				irq_pend <= 1'b0;
			end
		end
	end

	assign irq_n = ~irq_pend;

endmodule

// File: sub_decode/sub_decode.sv
`timescale 1ns/10ps

`include "sys86_macros.svh"

module sub_decode (
	input  logic                     clk_6m,
	input  logic                     rst_n,
	input  logic [`SYS86_ADDR_W-1:0] addr,
	input  logic                     wr,
	input  logic                     sub_e,
	input  logic                     vblank,
	output sys86_bus_pkg::region_e   region,
	output logic                     irq_n
);

	logic vblank_q;
	logic vblank_rise;
	logic irq_pend;

	//////////////////////////////////////////////////
	// Sub address map
	//////////////////////////////////////////////////

	always_comb begin
		region = sys86_bus_pkg::REG_NONE;
		if (sys86_bus_pkg::in_window(addr, `SYS86_SCROLL0_BASE, `SYS86_WIN_8K))
			region = sys86_bus_pkg::REG_SCROLL0;
		else if (sys86_bus_pkg::in_window(addr, `SYS86_SCROLL1_BASE, `SYS86_WIN_8K))
			region = sys86_bus_pkg::REG_SCROLL1;
		else if (sys86_bus_pkg::in_window(addr, `SYS86_OBJECT_BASE, `SYS86_WIN_8K))
			region = sys86_bus_pkg::REG_OBJECT;
		else if (!wr) begin
			// No bank on this side, ROM_HI covers the whole upper half
			if (sys86_bus_pkg::in_window(addr, `SYS86_S_ROM_LO_BASE, `SYS86_WIN_8K))
				region = sys86_bus_pkg::REG_ROM_LO;
			else if (sys86_bus_pkg::in_window(addr, `SYS86_S_ROM_HI_BASE, `SYS86_S_ROM_HI_SIZE))
				region = sys86_bus_pkg::REG_ROM_HI;
		end else begin
			if (sys86_bus_pkg::in_window(addr, `SYS86_S_LATCH0, `SYS86_WIN_1K))
				region = sys86_bus_pkg::REG_LATCH0;
			else if (sys86_bus_pkg::in_window(addr, `SYS86_S_LATCH1, `SYS86_WIN_1K))
				region = sys86_bus_pkg::REG_LATCH1;
			else if (sys86_bus_pkg::in_window(addr, `SYS86_S_IRQ_ACK, `SYS86_WIN_1K))
				region = sys86_bus_pkg::REG_IRQ_ACK;
		end
	end

	//////////////////////////////////////////////////
	// Vblank interrupt flag
	//////////////////////////////////////////////////

	assign vblank_rise = vblank & ~vblank_q;

	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n) begin
			vblank_q <= 1'b0;
			irq_pend <= 1'b0;
		end else begin
			vblank_q <= vblank;
			if (vblank_rise) begin
				irq_pend <= 1'b1;
			end else if (sub_e && region == sys86_bus_pkg::REG_IRQ_ACK) begin
				irq_pend <= 1'b0;
			end
		end
	end

	assign irq_n = ~irq_pend;

endmodule

// File: verilog/bus_mux.sv
`timescale 1ns/10ps

`include "sys86_macros.svh"

module bus_mux (
	input  logic                         clk_6m,
	input  logic                         rst_n,
	input  sys86_cpu_pkg::phase_e        phase,
	input  logic [`SYS86_ADDR_W-1:0]     master_addr,
	input  logic                         master_wr,
	input  logic [`SYS86_DATA_W-1:0]     master_wdata,
	input  sys86_bus_pkg::region_e       master_region,
	input  logic                         master_bank,
	input  logic [`SYS86_ADDR_W-1:0]     sub_addr,
	input  logic                         sub_wr,
	input  logic [`SYS86_DATA_W-1:0]     sub_wdata,
	input  sys86_bus_pkg::region_e       sub_region,
	input  logic [`SYS86_DATA_W-1:0]     bus_rdata,
	input  logic [`SYS86_DATA_W-1:0]     rom_9c_data,
	input  logic [`SYS86_DATA_W-1:0]     rom_9d_data,
	input  logic [`SYS86_DATA_W-1:0]     rom_12c_data,
	input  logic [`SYS86_DATA_W-1:0]     rom_12d_data,
	output logic [`SYS86_BUS_ADDR_W-1:0] bus_addr,
	output logic [`SYS86_DATA_W-1:0]     bus_wdata,
	output logic                         bus_we_n,
	output logic                         scroll0_n,
	output logic                         scroll1_n,
	output logic                         object_n,
	output logic                         latch0_n,
	output logic                         latch1_n,
	output logic                         backcolor_n,
	output logic [`SYS86_ROM_ADDR_W-1:0] rom_9c_addr,
	output logic [`SYS86_ROM_ADDR_W-1:0] rom_9d_addr,
	output logic [`SYS86_ROM_ADDR_W-1:0] rom_12c_addr,
	output logic [`SYS86_ROM_ADDR_W-1:0] rom_12d_addr,
	output logic                         rom_9c_ce,
	output logic                         rom_9d_ce,
	output logic                         rom_12c_ce,
	output logic                         rom_12d_ce,
	output logic [`SYS86_DATA_W-1:0]     master_rdata,
	output logic [`SYS86_DATA_W-1:0]     sub_rdata
);

	logic                         master_slot;
	logic                         b_cycle;
	logic [`SYS86_ADDR_W-1:0]     sel_addr;
	logic                         sel_wr;
	sys86_bus_pkg::region_e       sel_region;
	logic [`SYS86_DATA_W-1:0]     sel_rdata;

	//////////////////////////////////////////////////
	// Slot owner onto the video bus
	//////////////////////////////////////////////////

	assign master_slot = sys86_cpu_pkg::is_master_slot(phase);
	assign b_cycle     = sys86_cpu_pkg::is_b_cycle(phase);

	assign sel_addr   = master_slot ? master_addr : sub_addr;
	assign sel_wr     = master_slot ? master_wr : sub_wr;
	assign sel_region = master_slot ? master_region : sub_region;
	assign bus_wdata  = master_slot ? master_wdata : sub_wdata;

	assign bus_addr = (sel_region == sys86_bus_pkg::REG_NONE) ? '0 :
		sel_addr[`SYS86_BUS_ADDR_W-1:0];

	// Chip selects span the slot, strobes only the B cycle
	assign scroll0_n   = ~(sel_region == sys86_bus_pkg::REG_SCROLL0);
	assign scroll1_n   = ~(sel_region == sys86_bus_pkg::REG_SCROLL1);
	assign object_n    = ~(sel_region == sys86_bus_pkg::REG_OBJECT);
	assign bus_we_n    = ~(b_cycle && sel_wr && sys86_bus_pkg::is_video(sel_region));
	assign latch0_n    = ~(b_cycle && sel_region == sys86_bus_pkg::REG_LATCH0);
	assign latch1_n    = ~(b_cycle && sel_region == sys86_bus_pkg::REG_LATCH1);
	assign backcolor_n = ~(b_cycle && sel_region == sys86_bus_pkg::REG_BACKCOLOR);

	//////////////////////////////////////////////////
	// Program ROMs
	//////////////////////////////////////////////////

	assign rom_9c_ce  = master_slot && master_region == sys86_bus_pkg::REG_ROM_HI;
	assign rom_9d_ce  = master_slot && master_region == sys86_bus_pkg::REG_ROM_LO;
	assign rom_12c_ce = !master_slot && sub_region == sys86_bus_pkg::REG_ROM_HI;
	assign rom_12d_ce = !master_slot && sub_region == sys86_bus_pkg::REG_ROM_LO;

	assign rom_9c_addr  = master_addr[`SYS86_ROM_ADDR_W-1:0];
	// Bank bit picks the 8K page of 9d
	assign rom_9d_addr  = {1'b0, master_bank, master_addr[12:0]};
	assign rom_12c_addr = sub_addr[`SYS86_ROM_ADDR_W-1:0];
	assign rom_12d_addr = sub_addr[`SYS86_ROM_ADDR_W-1:0];

	//////////////////////////////////////////////////
	// Read data capture
	//////////////////////////////////////////////////

	always_comb begin
		case (sel_region)
			sys86_bus_pkg::REG_ROM_HI:  sel_rdata = master_slot ? rom_9c_data : rom_12c_data;
			sys86_bus_pkg::REG_ROM_LO:  sel_rdata = master_slot ? rom_9d_data : rom_12d_data;
			sys86_bus_pkg::REG_SCROLL0,
			sys86_bus_pkg::REG_SCROLL1,
			sys86_bus_pkg::REG_OBJECT:  sel_rdata = bus_rdata;
			default:                    sel_rdata = 8'hFF;
		endcase
	end

	// Held until the owner's next E cycle
	always_ff @(posedge clk_6m or negedge rst_n) begin
		if (!rst_n) begin
			master_rdata <= 8'hFF;
			sub_rdata    <= 8'hFF;
		end else if (phase == sys86_cpu_pkg::PH_MASTER_B) begin
			master_rdata <= sel_rdata;
		end else if (phase == sys86_cpu_pkg::PH_SUB_B) begin
			sub_rdata <= sel_rdata;
		end
	end

endmodule

// File: verilog/cpu_subsystem.sv
`timescale 1ns/10ps

`include "sys86_macros.svh"

module cpu_subsystem (
	input  logic                         clk_6m,
	input  logic                         rst_n,
	input  logic                         vblank,
	// Master CPU
	input  logic [`SYS86_ADDR_W-1:0]     master_addr,
	input  logic                         master_wr,
	input  logic [`SYS86_DATA_W-1:0]     master_wdata,
	output logic [`SYS86_DATA_W-1:0]     master_rdata,
	output logic                         master_e,
	output logic                         master_irq_n,
	// Sub CPU
	input  logic [`SYS86_ADDR_W-1:0]     sub_addr,
	input  logic                         sub_wr,
	input  logic [`SYS86_DATA_W-1:0]     sub_wdata,
	output logic [`SYS86_DATA_W-1:0]     sub_rdata,
	output logic                         sub_e,
	output logic                         sub_irq_n,
	output logic                         cpu_reset_n,
	// Video bus
	input  logic [`SYS86_DATA_W-1:0]     bus_rdata,
	output logic [`SYS86_BUS_ADDR_W-1:0] bus_addr,
	output logic [`SYS86_DATA_W-1:0]     bus_wdata,
	output logic                         bus_we_n,
	output logic                         scroll0_n,
	output logic                         scroll1_n,
	output logic                         object_n,
	output logic                         latch0_n,
	output logic                         latch1_n,
	output logic                         backcolor_n,
	// Program ROMs
	input  logic [`SYS86_DATA_W-1:0]     rom_9c_data,
	input  logic [`SYS86_DATA_W-1:0]     rom_9d_data,
	input  logic [`SYS86_DATA_W-1:0]     rom_12c_data,
	input  logic [`SYS86_DATA_W-1:0]     rom_12d_data,
	output logic [`SYS86_ROM_ADDR_W-1:0] rom_9c_addr,
	output logic [`SYS86_ROM_ADDR_W-1:0] rom_9d_addr,
	output logic [`SYS86_ROM_ADDR_W-1:0] rom_12c_addr,
	output logic [`SYS86_ROM_ADDR_W-1:0] rom_12d_addr,
	output logic                         rom_9c_ce,
	output logic                         rom_9d_ce,
	output logic                         rom_12c_ce,
	output logic                         rom_12d_ce
);

	sys86_cpu_pkg::phase_e  phase;
	sys86_bus_pkg::region_e master_region;
	sys86_bus_pkg::region_e sub_region;
	logic                   master_bank;
	logic                   reset_req;

	cpu_timing u_timing (
		.clk_6m      (clk_6m),
		.rst_n       (rst_n),
		.reset_req   (reset_req),
		.phase       (phase),
		.master_e    (master_e),
		.sub_e       (sub_e),
		.cpu_reset_n (cpu_reset_n)
	);

	master_decode u_master_decode (
		.clk_6m    (clk_6m),
		.rst_n     (rst_n),
		.addr      (master_addr),
		.wr        (master_wr),
		.wdata     (master_wdata),
		.master_e  (master_e),
		.vblank    (vblank),
		.region    (master_region),
		.bank      (master_bank),
		.irq_n     (master_irq_n),
		.reset_req (reset_req)
	);

	sub_decode u_sub_decode (
		.clk_6m (clk_6m),
		.rst_n  (rst_n),
		.addr   (sub_addr),
		.wr     (sub_wr),
		.sub_e  (sub_e),
		.vblank (vblank),
		.region (sub_region),
		.irq_n  (sub_irq_n)
	);

	// Every bus_mux port shares its name with a port or wire here
	bus_mux u_bus_mux (.*);

endmodule

// File: sim/tb_cpu_subsystem.sv
`timescale 1ns/10ps

`include "sys86_macros.svh"

module tb_cpu_subsystem;

	localparam int          TIMEOUT_CYCLES = 64;
	localparam int          VRAM_WORDS     = 3 * 8192;
	// Unmapped on writes for both CPUs
	localparam logic [15:0] IDLE_ADDR      = 16'hF000;

	typedef struct packed {
		logic [2:0]  cs;     // scroll0_n, scroll1_n, object_n
		logic        we_n;
		logic [2:0]  strb;   // latch0_n, latch1_n, backcolor_n
		logic [12:0] addr;
		logic [7:0]  wdata;
		logic [3:0]  ce;     // 9c, 9d, 12c, 12d
	} snap_t;

	logic clk_6m, rst_n, vblank;
	logic [`SYS86_ADDR_W-1:0] master_addr, sub_addr;
	logic master_wr, sub_wr, master_e, sub_e, master_irq_n, sub_irq_n, cpu_reset_n;
	logic [`SYS86_DATA_W-1:0] master_wdata, sub_wdata, master_rdata, sub_rdata;
	logic [`SYS86_DATA_W-1:0] bus_rdata, bus_wdata;
	logic [`SYS86_BUS_ADDR_W-1:0] bus_addr;
	logic bus_we_n, scroll0_n, scroll1_n, object_n, latch0_n, latch1_n, backcolor_n;
	logic [`SYS86_DATA_W-1:0] rom_9c_data, rom_9d_data, rom_12c_data, rom_12d_data;
	logic [`SYS86_ROM_ADDR_W-1:0] rom_9c_addr, rom_9d_addr, rom_12c_addr, rom_12d_addr;
	logic rom_9c_ce, rom_9d_ce, rom_12c_ce, rom_12d_ce;

	logic [7:0] vram [0:VRAM_WORDS-1];
	logic [1:0] vram_bank;
	int         checks;
	int         errors;

	cpu_subsystem uut (.*);

	//////////////////////////////////////////////////
	// ROM and video RAM models
	//////////////////////////////////////////////////

	function automatic logic [7:0] rom_pattern(input logic [1:0] id, input logic [14:0] a);
		return (a[7:0] + {a[14:8], 1'b1}) ^ {id, 2'b01, id, 2'b10};
	endfunction

	assign rom_9c_data  = rom_pattern(2'd0, rom_9c_addr);
	assign rom_9d_data  = rom_pattern(2'd1, rom_9d_addr);
	assign rom_12c_data = rom_pattern(2'd2, rom_12c_addr);
	assign rom_12d_data = rom_pattern(2'd3, rom_12d_addr);

	// One 8K page per chip select
	assign vram_bank = !scroll0_n ? 2'd0 : (!scroll1_n ? 2'd1 : 2'd2);
	assign bus_rdata = (scroll0_n & scroll1_n & object_n) ? 8'hFF : vram[{vram_bank, bus_addr}];

	always @(posedge clk_6m) begin
		if (!bus_we_n) begin
			vram[{vram_bank, bus_addr}] <= bus_wdata;
		end
	end

	initial begin
		clk_6m = 1'b0;
		forever #20 clk_6m = ~clk_6m;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic end_run();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic step();
		@(posedge clk_6m);
		#2;
	endtask

	function automatic snap_t take_snap();
		snap_t s;
		s.cs    = {scroll0_n, scroll1_n, object_n};
		s.we_n  = bus_we_n;
		s.strb  = {latch0_n, latch1_n, backcolor_n};
		s.addr  = bus_addr;
		s.wdata = bus_wdata;
		s.ce    = {rom_9c_ce, rom_9d_ce, rom_12c_ce, rom_12d_ce};
		return s;
	endfunction

	task automatic drive_cpu(input bit master_cpu, input logic [15:0] addr, input logic wr,
		input logic [7:0] wdata);
		if (master_cpu) begin
			master_addr  = addr;
			master_wr    = wr;
			master_wdata = wdata;
		end else begin
			sub_addr  = addr;
			sub_wr    = wr;
			sub_wdata = wdata;
		end
	endtask

	// Returns in the E cycle with prev from the cycle before
	task automatic wait_strobe(input bit master_cpu, output snap_t prev);
		int n;
		n = 0;
		prev = take_snap();
		while ((master_cpu ? master_e : sub_e) !== 1'b1) begin
			prev = take_snap();
			step();
			n++;
			if (n > TIMEOUT_CYCLES) begin
				$display("Timeout waiting for the %s E strobe", master_cpu ? "master" : "sub");
				errors++;
				end_run();
			end
		end
	endtask

	// One CPU bus cycle driven after E and held for a frame
	task automatic cpu_access(input bit master_cpu, input logic [15:0] addr, input logic wr,
		input logic [7:0] wdata, output snap_t a, output snap_t b, output snap_t c,
		output logic [7:0] rdata);
		snap_t dummy;
		wait_strobe(master_cpu, dummy);
		step();
		drive_cpu(master_cpu, addr, wr, wdata);
		wait_strobe(master_cpu, a);
		b = take_snap();
		step();
		c = take_snap();
		rdata = master_cpu ? master_rdata : sub_rdata;
		drive_cpu(master_cpu, IDLE_ADDR, 1'b1, 8'h00);
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic reset_and_slots();
		int n;
		sys86_cpu_pkg::phase_e ph;
		snap_t prev;
		n = 0;
		check_val("cpu_reset_n", cpu_reset_n, 1'b0);
		rst_n = 1'b1;
		while (cpu_reset_n !== 1'b1) begin
			check_val("strobes", {scroll0_n, scroll1_n, object_n, latch0_n, latch1_n,
				backcolor_n, bus_we_n}, 7'h7F);
			check_val("irq_n", {master_irq_n, sub_irq_n}, 2'b11);
			check_val("rom ce", {rom_9c_ce, rom_9d_ce, rom_12c_ce, rom_12d_ce}, 4'h0);
			step();
			n++;
			if (n > TIMEOUT_CYCLES) begin
				$display("Timeout waiting for cpu_reset_n to rise");
				errors++;
				end_run();
			end
		end
		check_val("cpu_reset_n low cycles", n, `SYS86_RESET_CYCLES);
		wait_strobe(1'b1, prev);
		ph = sys86_cpu_pkg::PH_MASTER_B;
		for (int k = 0; k < 8; k++) begin
			check_val("master_e", master_e, ph == sys86_cpu_pkg::PH_MASTER_B);
			check_val("sub_e", sub_e, ph == sys86_cpu_pkg::PH_SUB_B);
			ph = sys86_cpu_pkg::phase_e'(ph + 2'd1);
			step();
		end
	endtask

	task automatic video_result(input string rd_name, input logic [1:0] rg,
		input logic [12:0] off, input logic wr, input logic [7:0] data,
		input logic [7:0] exp_rd, input snap_t a, input snap_t b, input logic [7:0] rd);
		logic [2:0] cs_exp;
		cs_exp = ~(3'b100 >> rg);
		check_val("scroll0_n,scroll1_n,object_n (A)", a.cs, cs_exp);
		check_val("scroll0_n,scroll1_n,object_n (B)", b.cs, cs_exp);
		check_val("bus_addr", b.addr, off);
		check_val("bus_we_n (A)", a.we_n, 1'b1);
		check_val("bus_we_n (B)", b.we_n, !wr);
		if (wr) begin
			check_val("bus_wdata", b.wdata, data);
			check_val("vram", vram[{rg, off}], data);
		end else begin
			check_val(rd_name, rd, exp_rd);
		end
	endtask

	task automatic video_sharing();
		snap_t ma, mb, mc, sa, sb, sc;
		logic [7:0] m_rd, s_rd, m_data, s_data, m_exp, s_exp;
		logic [1:0] m_reg, s_reg;
		logic [12:0] m_off, s_off;
		logic m_wr, s_wr;
		for (int i = 0; i < 16; i++) begin
			// Master uses the low half of each page and sub the high half
			m_reg  = 2'($urandom_range(2, 0));
			s_reg  = 2'($urandom_range(2, 0));
			m_off  = {1'b0, 12'($urandom)};
			s_off  = {1'b1, 12'($urandom)};
			m_wr   = 1'($urandom);
			s_wr   = 1'($urandom);
			m_data = 8'($urandom);
			s_data = 8'($urandom);
			m_exp  = vram[{m_reg, m_off}];
			s_exp  = vram[{s_reg, s_off}];
			fork
				cpu_access(1'b1, {1'b0, m_reg, m_off}, m_wr, m_data, ma, mb, mc, m_rd);
				cpu_access(1'b0, {1'b0, s_reg, s_off}, s_wr, s_data, sa, sb, sc, s_rd);
			join
			video_result("master_rdata", m_reg, m_off, m_wr, m_data, m_exp, ma, mb, m_rd);
			video_result("sub_rdata", s_reg, s_off, s_wr, s_data, s_exp, sa, sb, s_rd);
		end
	endtask

	task automatic rom_read(input bit master_cpu, input logic [15:0] addr,
		input logic [3:0] ce_exp, input logic [7:0] data_exp);
		snap_t a, b, c;
		logic [7:0] rd;
		cpu_access(master_cpu, addr, 1'b0, 8'h00, a, b, c, rd);
		check_val("rom ce 9c,9d,12c,12d (A)", a.ce, ce_exp);
		check_val("rom ce 9c,9d,12c,12d (B)", b.ce, ce_exp);
		check_val(master_cpu ? "master_rdata" : "sub_rdata", rd, data_exp);
	endtask

	task automatic rom_banking();
		snap_t a, b, c;
		logic [7:0] rd;
		logic [15:0] fixed, banked, sub_hi, sub_lo;
		fixed  = 16'hA000 + 16'($urandom_range(16'h5FFF, 0));
		banked = {3'b011, 13'($urandom)};
		sub_hi = {1'b1, 15'($urandom)};
		sub_lo = {3'b011, 13'($urandom)};
		rom_read(1'b1, fixed, 4'b1000, rom_pattern(2'd0, fixed[14:0]));
		// Bank is 0 out of reset
		rom_read(1'b1, banked, 4'b0100, rom_pattern(2'd1, {2'b00, banked[12:0]}));
		for (int bk = 1; bk >= 0; bk--) begin
			cpu_access(1'b1, 16'h9000, 1'b1, 8'(bk), a, b, c, rd);
			rom_read(1'b1, banked, 4'b0100, rom_pattern(2'd1, {1'b0, 1'(bk), banked[12:0]}));
		end
		rom_read(1'b0, sub_hi, 4'b0010, rom_pattern(2'd2, sub_hi[14:0]));
		rom_read(1'b0, sub_lo, 4'b0001, rom_pattern(2'd3, sub_lo[14:0]));
		// Writes to ROM decode to nothing
		cpu_access(1'b1, fixed, 1'b1, 8'h5A, a, b, c, rd);
		check_val("rom ce 9c,9d,12c,12d", b.ce, 4'h0);
		check_val("master_rdata", rd, 8'hFF);
		cpu_access(1'b0, sub_lo, 1'b1, 8'hA5, a, b, c, rd);
		check_val("rom ce 9c,9d,12c,12d", b.ce, 4'h0);
		check_val("sub_rdata", rd, 8'hFF);
		rom_read(1'b1, fixed, 4'b1000, rom_pattern(2'd0, fixed[14:0]));
	endtask

	task automatic strobe_write(input bit master_cpu, input logic [15:0] base,
		input logic [2:0] strb_exp);
		snap_t a, b, c;
		logic [7:0] rd, data;
		logic [15:0] addr;
		data = 8'($urandom);
		addr = base | 16'($urandom_range(16'h3FF, 0));
		cpu_access(master_cpu, addr, 1'b1, data, a, b, c, rd);
		check_val("latch0_n,latch1_n,backcolor_n (A)", a.strb, 3'b111);
		check_val("latch0_n,latch1_n,backcolor_n (B)", b.strb, strb_exp);
		check_val("latch0_n,latch1_n,backcolor_n (after)", c.strb, 3'b111);
		check_val("bus_wdata", b.wdata, data);
		check_val("bus_we_n", b.we_n, 1'b1);
	endtask

	task automatic latch_strobes();
		strobe_write(1'b1, 16'h8000, 3'b011);
		strobe_write(1'b1, 16'h8400, 3'b101);
		strobe_write(1'b1, 16'h8800, 3'b110);
		strobe_write(1'b0, 16'h8000, 3'b011);
		strobe_write(1'b0, 16'h8400, 3'b101);
	endtask

	task automatic vblank_irqs();
		snap_t a, b, c;
		logic [7:0] rd;
		for (int round = 0; round < 2; round++) begin
			vblank = 1'b1;
			step();
			vblank = 1'b0;
			check_val("master_irq_n", master_irq_n, 1'b0);
			check_val("sub_irq_n", sub_irq_n, 1'b0);
			// Ack order swaps between the two rounds
			cpu_access(round == 0, round == 0 ? 16'h9400 : 16'h8800, 1'b1, 8'h00, a, b, c, rd);
			check_val("master_irq_n", master_irq_n, round == 0);
			check_val("sub_irq_n", sub_irq_n, round != 0);
			cpu_access(round != 0, round == 0 ? 16'h8800 : 16'h9400, 1'b1, 8'h00, a, b, c, rd);
			check_val("master_irq_n", master_irq_n, 1'b1);
			check_val("sub_irq_n", sub_irq_n, 1'b1);
		end
	endtask

	task automatic reset_request();
		snap_t a, b, c;
		logic [7:0] rd;
		int n, low, pulses;
		n = 0;
		low = 0;
		pulses = 0;
		cpu_access(1'b1, 16'h9800, 1'b1, 8'h00, a, b, c, rd);
		while (cpu_reset_n !== 1'b0) begin
			step();
			n++;
			if (n > TIMEOUT_CYCLES) begin
				$display("Timeout waiting for cpu_reset_n to fall after a reset write");
				errors++;
				end_run();
			end
		end
		while (cpu_reset_n !== 1'b1) begin
			if (master_e) begin
				pulses++;
			end
			step();
			low++;
			if (low > TIMEOUT_CYCLES) begin
				$display("Timeout waiting for cpu_reset_n to rise after a reset write");
				errors++;
				end_run();
			end
		end
		check_val("cpu_reset_n low cycles", low, `SYS86_RESET_CYCLES);
		check_val("master_e pulses during reset", pulses,
			`SYS86_RESET_CYCLES / `SYS86_FRAME_CYCLES);
	endtask

	//////////////////////////////////////////////////
	// Sequence
	//////////////////////////////////////////////////

	initial begin
		void'($urandom(32'ha9fdeacc));
		checks = 0;
		errors = 0;
		rst_n  = 1'b0;
		vblank = 1'b0;
		drive_cpu(1'b1, IDLE_ADDR, 1'b1, 8'h00);
		drive_cpu(1'b0, IDLE_ADDR, 1'b1, 8'h00);
		for (int i = 0; i < VRAM_WORDS; i++) begin
			vram[i] = 8'(i) ^ 8'(i >> 7) ^ 8'h5A;
		end
		repeat (5) @(posedge clk_6m);
		#2;
		reset_and_slots();
		video_sharing();
		rom_banking();
		latch_strobes();
		vblank_irqs();
		reset_request();
		end_run();
	end

endmodule

// File: cpu_subsystem.f
+incdir+common
common/sys86_bus_pkg.sv
common/sys86_cpu_pkg.sv
verilog/cpu_timing.sv
master_decode/master_decode.sv
sub_decode/sub_decode.sv
verilog/bus_mux.sv
verilog/cpu_subsystem.sv
sim/tb_cpu_subsystem.sv

// File: Bender.yml
package:
  name: cpu_subsystem

sources:
  - include_dirs:
      - common
    files:
      - common/sys86_bus_pkg.sv
      - common/sys86_cpu_pkg.sv
      - verilog/cpu_timing.sv
      - master_decode/master_decode.sv
      - sub_decode/sub_decode.sv
      - verilog/bus_mux.sv
      - verilog/cpu_subsystem.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/tb_cpu_subsystem.sv
